/* source/scope_pkg.sv */
package scope_pkg;

    // One audio sample as it arrives from the outside
    typedef logic signed [15:0] sample_t;

    // One stored sample in offset binary, 0 is the most negative level
    typedef logic [7:0] pixel_t;

    // Position of a sample inside one bank of the waveform RAM
    typedef logic [7:0] addr_t;

    // Capture FSM, ARMED looks for a crossing and WAIT holds a finished frame
    typedef enum logic [1:0] {
        ARMED  = 2'd0,
        ACTIVE = 2'd1,
        WAIT   = 2'd2
    } capture_state_t;

    typedef struct packed {
        logic   enable;     // Write strobe for this cycle
        logic   bank;       // Bank that the capture side owns
        addr_t  addr;       // Sample index inside the bank
        pixel_t data;       // Converted sample
    } ram_write_t;

    typedef struct packed {
        logic   valid;      // Beat present on the display link
        addr_t  index;      // Sample index within the frame
        pixel_t value;      // Stored sample value
        logic   last;       // Final beat of the frame
    } display_beat_t;

    // Top byte with the sign flipped maps -32768 to 0 and 0 to 128
    function automatic pixel_t to_pixel(input sample_t sample);
        return {~sample[15], sample[14:8]};
    endfunction

endpackage

/* source/wave_capture.sv */
`timescale 1ns/1ps

module wave_capture #(
    parameter int WAVE_DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sample_valid,
    input  scope_pkg::sample_t    sample_in,
    input  logic                  swap,
    output scope_pkg::ram_write_t ram_write,
    output logic                  write_bank,
    output logic                  frame_ready
);
    import scope_pkg::*;

    capture_state_t             state;
    logic                       prev_sign;  // Sign bit of the last accepted sample
    logic [WAVE_DEPTH_LOG2-1:0] count;      // Index that the next write goes to
    logic                       trigger;    // Crossing seen on an accepted sample
    logic                       write_now;  // Current sample goes into the RAM

    // A negative sample followed by a nonnegative one arms the capture
    assign trigger = (state == ARMED) && sample_valid && prev_sign && !sample_in[15];

    // The triggering sample is already part of the frame
    assign write_now = trigger || ((state == ACTIVE) && sample_valid);

    // Writes follow the input in the same cycle
    always_comb begin
        ram_write.enable = write_now;
        ram_write.bank   = write_bank;          // Capture always fills its own bank
        ram_write.addr   = addr_t'(count);
        ram_write.data   = to_pixel(sample_in);
    end

    assign frame_ready = (state == WAIT);       // Level to the reader while a frame is held

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ARMED;
            prev_sign  <= 1'b0;
            count      <= '0;
            write_bank <= 1'b1;                 // Reader starts on bank 0
        end else begin
            // The crossing detector sees every accepted sample in every state
            if (sample_valid) begin
                prev_sign <= sample_in[15];
            end

            // Counter wraps back to zero after the last index
            if (write_now) begin
                count <= count + 1'b1;
            end

            case (state)
                ARMED: begin
                    if (trigger) begin
                        state <= ACTIVE;        // Index 0 was written this cycle
                    end
                end
                ACTIVE: begin
                    if (sample_valid && (&count)) begin
                        state <= WAIT;          // Last index written and the frame is complete
                    end
                end
                WAIT: begin
                    // Reader took the frame, so move on to the other bank
                    if (swap) begin
                        state      <= ARMED;
                        write_bank <= ~write_bank;
                    end
                end
                default: begin
                    state <= ARMED;
                end
            endcase
        end
    end

    // Only a running capture or its triggering sample may touch the RAM
    // and a new frame always opens at index 0
    a_write_window: assert property (
        @(posedge clk) disable iff (reset)
        ram_write.enable |-> (state == ACTIVE) ||
            ((state == ARMED) && (ram_write.addr == '0))
    );

    // The reader must not take the bank away while it is still being filled
    a_swap_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        swap |-> (state == WAIT)
    );

endmodule

/* source/wave_ram.sv */
`timescale 1ns/1ps

module wave_ram #(
    parameter int WAVE_DEPTH_LOG2 = 8
) (
    input  logic                  clk,
    input  scope_pkg::ram_write_t ram_write,
    input  logic [WAVE_DEPTH_LOG2:0] read_addr,    // Bank in the top bit, index below
    output scope_pkg::pixel_t     read_data
);
    import scope_pkg::*;

    // Two banks of one frame each
    localparam int WORDS = 2 << WAVE_DEPTH_LOG2;

    pixel_t                   mem [WORDS];
    logic [WAVE_DEPTH_LOG2:0] write_addr;

    // Same layout as the read side so both banks share one array
    assign write_addr = {ram_write.bank, ram_write.addr[WAVE_DEPTH_LOG2-1:0]};

    // Write lands on the clock edge
    always_ff @(posedge clk) begin
        if (ram_write.enable) begin
            mem[write_addr] <= ram_write.data;
        end
    end

    // Registered read, data shows up one clock after the address
    always_ff @(posedge clk) begin
        read_data <= mem[read_addr];
    end

    // Capture and reader never share a bank, so reads and writes
    // in the same cycle always hit different halves of the array

endmodule

/* source/wave_reader.sv */
`timescale 1ns/1ps

module wave_reader #(
    parameter int WAVE_DEPTH_LOG2 = 8,
    parameter int DISPLAY_CREDITS = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     frame_ready,
    input  logic                     write_bank,
    output logic                     swap,
    output logic [WAVE_DEPTH_LOG2:0] read_addr,
    input  scope_pkg::pixel_t        read_data,
    input  logic                     credit_return,
    output scope_pkg::display_beat_t beat
);
    import scope_pkg::*;

    localparam int CREDIT_BITS = $clog2(DISPLAY_CREDITS + 1);

    typedef enum logic {
        IDLE   = 1'b0,
        STREAM = 1'b1
    } reader_state_t;

    reader_state_t              state;
    logic [WAVE_DEPTH_LOG2:0]   issue_count;    // Top bit set once every index is issued
    logic [CREDIT_BITS-1:0]     credits;        // Credits not yet reserved by an issue
    logic                       issue;          // Address goes to the RAM this cycle
    logic                       pend_valid;     // RAM read in flight
    logic [WAVE_DEPTH_LOG2-1:0] pend_index;
    logic                       pend_last;

    // Take a finished frame as soon as the display side has gone quiet
    assign swap = frame_ready && (state == IDLE);

    // Capture has already toggled write_bank when streaming starts
    assign read_addr = {~write_bank, issue_count[WAVE_DEPTH_LOG2-1:0]};

    // One index per clock while credits remain, otherwise the address is held
    assign issue = (state == STREAM) && !issue_count[WAVE_DEPTH_LOG2] && (credits != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            issue_count <= '0;
            credits     <= CREDIT_BITS'(DISPLAY_CREDITS);
        end else begin
            case (state)
                IDLE: begin
                    if (swap) begin
                        state       <= STREAM;
                        issue_count <= '0;      // Index 0 goes out on the next clock
                    end
                end
                STREAM: begin
                    if (issue) begin
                        issue_count <= issue_count + 1'b1;
                    end
                    if (beat.valid && beat.last) begin
                        state <= IDLE;          // Frame fully delivered
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            // A credit is reserved at issue and comes back from the sink later
            case ({issue, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Address stage then beat stage, so two indices can be in flight
    always_ff @(posedge clk) begin
        pend_index  <= issue_count[WAVE_DEPTH_LOG2-1:0];
        pend_last   <= &issue_count[WAVE_DEPTH_LOG2-1:0];
        beat.index  <= addr_t'(pend_index);
        beat.value  <= read_data;               // RAM output lines up with pend_index
        beat.last   <= pend_last;
        if (reset) begin
            pend_valid <= 1'b0;
            beat.valid <= 1'b0;
        end else begin
            pend_valid <= issue;
            beat.valid <= pend_valid;
        end
    end

    // Every beat on the link still holds the credit taken two clocks earlier
    a_beat_reserved: assert property (
        @(posedge clk) disable iff (reset)
        beat.valid |-> (credits < CREDIT_BITS'(DISPLAY_CREDITS))
    );

    // The sink cannot hand back more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        credits <= CREDIT_BITS'(DISPLAY_CREDITS)
    );

endmodule

/* source/scope_capture_top.sv */
`timescale 1ns/1ps

module scope_capture_top #(
    parameter int WAVE_DEPTH_LOG2 = 8,
    parameter int DISPLAY_CREDITS = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sample_valid,
    input  scope_pkg::sample_t       sample_in,
    input  logic                     credit_return,
    output scope_pkg::display_beat_t beat
);
    import scope_pkg::*;

    ram_write_t               ram_write;
    logic                     write_bank;   // Bank owned by the capture side
    logic                     frame_ready;  // Capture holds a complete frame
    logic                     swap;         // Reader takes the frame, one clock wide
    logic [WAVE_DEPTH_LOG2:0] read_addr;
    pixel_t                   read_data;

    // Producer with the trigger and bank ownership
    wave_capture #(.WAVE_DEPTH_LOG2(WAVE_DEPTH_LOG2)) u_capture (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .swap         (swap),
        .ram_write    (ram_write),
        .write_bank   (write_bank),
        .frame_ready  (frame_ready)
    );

    wave_ram #(.WAVE_DEPTH_LOG2(WAVE_DEPTH_LOG2)) u_ram (
        .clk       (clk),
        .ram_write (ram_write),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    // Consumer streaming the finished bank under credits
    wave_reader #(
        .WAVE_DEPTH_LOG2 (WAVE_DEPTH_LOG2),
        .DISPLAY_CREDITS (DISPLAY_CREDITS)
    ) u_reader (
        .clk           (clk),
        .reset         (reset),
        .frame_ready   (frame_ready),
        .write_bank    (write_bank),
        .swap          (swap),
        .read_addr     (read_addr),
        .read_data     (read_data),
        .credit_return (credit_return),
        .beat          (beat)
    );

endmodule

/* testbench/scope_tb.sv */
`timescale 1ns/1ps

module scope_tb;
    import scope_pkg::*;

    localparam int FRAME_MAX  = 1 << $bits(addr_t);     // One bank holds this many samples
    localparam int NUM_BURSTS = 5;                      // The last one runs with credits held
    localparam int WAIT_LIMIT = 5000;                   // Cycles any single wait may take

    logic          clk;
    logic          reset;
    logic          sample_valid;
    sample_t       sample_in;
    logic          credit_return;
    display_beat_t beat;

    logic          hold_credits;                        // Sink keeps every credit while set
    logic          stop_run;                            // Main sequence gave up on a wait
    logic          compare_done;
    logic [31:0]   stim_rng;
    sample_t       burst [$];                           // Samples of the burst being sent
    pixel_t        expected_q [$];
    display_beat_t beat_q [$];
    int            beats_total   = 0;
    int            returns_total = 0;
    int            pixel_errors  = 0;
    int            index_errors  = 0;
    int            flag_errors   = 0;
    int            credit_errors = 0;
    int            other_errors  = 0;

    scope_capture_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .sample_valid  (sample_valid),
        .sample_in     (sample_in),
        .credit_return (credit_return),
        .beat          (beat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 32-bit xorshift, each process keeps its own state
    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = state ^ (state << 13);
        state = state ^ (state >> 17);
        state = state ^ (state << 5);
        return state;
    endfunction

    function automatic sample_t random_sample(input logic force_sign, input logic sign);
        sample_t value;
        value = sample_t'(next_random(stim_rng));
        if (force_sign)
            value[15] = sign;
        return value;
    endfunction

    // Noise, crossing, frame body, nonnegative extras and then a negative tail
    function automatic void build_burst();
        burst.delete();
        repeat (1 + int'(next_random(stim_rng) % 16)) burst.push_back(random_sample(1'b1, 1'b1));
        burst.push_back(random_sample(1'b1, 1'b0));
        repeat (FRAME_MAX - 2) burst.push_back(random_sample(1'b0, 1'b0));
        // Index 255 and the extras stay nonnegative so they hold no second crossing
        repeat (2 + int'(next_random(stim_rng) % 8)) burst.push_back(random_sample(1'b1, 1'b0));
        repeat (1 + int'(next_random(stim_rng) % 8)) burst.push_back(random_sample(1'b1, 1'b1));
    endfunction

    // First negative to nonnegative step starts the frame, which then runs for one bank
    function automatic void expected_frame(input sample_t samples [$], input logic prev_sign,
                                           output pixel_t frame [FRAME_MAX]);
        logic sign_before;
        int   start;
        sign_before = prev_sign;
        start = -1;
        foreach (samples[i]) begin
            if (start < 0 && sign_before && !samples[i][15])
                start = i;
            sign_before = samples[i][15];
        end
        foreach (frame[i])
            frame[i] = pixel_t'((int'(samples[start + i]) + 32768) >> 8);  // Shift up by half range
    endfunction

    task automatic check_pixel(input pixel_t got, input pixel_t want, input int f, input int i);
        if (got !== want) begin
            pixel_errors++;
            $display("ERROR at %0t: frame %0d index %0d value %0d, expected %0d",
                     $time, f, i, got, want);
        end
    endtask

    task automatic check_index(input addr_t got, input addr_t want, input int f);
        if (got !== want) begin
            index_errors++;
            $display("ERROR at %0t: frame %0d index %0d, expected %0d", $time, f, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            flag_errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // Idle cycles in front of each sample give random gaps in sample_valid
    task automatic send_sample(input sample_t value);
        while (next_random(stim_rng) % 4 == 0) begin
            @(negedge clk);
            sample_valid = 1'b0;
            sample_in    = sample_t'(next_random(stim_rng));  // Junk that must be ignored
        end
        @(negedge clk);
        sample_valid = 1'b1;
        sample_in    = value;
    endtask

    task automatic wait_for_beats(input int target, input logic drained, input string what);
        int waited;
        waited = 0;
        while (!stop_run && waited < WAIT_LIMIT &&
               (beats_total < target || (drained && returns_total != beats_total))) begin
            @(negedge clk);
            waited++;
        end
        if (!stop_run && (beats_total < target || (drained && returns_total != beats_total))) begin
            $display("Timeout while waiting for %s", what);
            other_errors++;
            stop_run = 1'b1;
        end
    endtask

    task automatic report_and_finish();
        $display("Error counts: pixel %0d, index %0d, flag %0d, credit %0d, other %0d",
                 pixel_errors, index_errors, flag_errors, credit_errors, other_errors);
        if (pixel_errors + index_errors + flag_errors + credit_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Display side, beats are sampled mid-cycle and each credit goes back later
    initial begin : display_sink
        int          due [$];
        int          cycle;
        logic [31:0] sink_rng;
        cycle         = 0;
        sink_rng      = 32'd69;
        credit_return = 1'b0;
        forever begin
            @(negedge clk);
            cycle++;
            if (beat.valid === 1'b1) begin
                beat_q.push_back(beat);
                beats_total++;
                due.push_back(cycle + 1 + int'(next_random(sink_rng) % 7));
                if (beats_total - returns_total > dut_i.DISPLAY_CREDITS) begin
                    credit_errors++;
                    $display("ERROR at %0t: %0d beats outstanding, only %0d credits",
                             $time, beats_total - returns_total, dut_i.DISPLAY_CREDITS);
                end
            end
            if (!hold_credits && due.size() > 0 && due[0] <= cycle) begin
                void'(due.pop_front());
                returns_total++;
                credit_return = 1'b1;                   // At most one credit per clock
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    initial begin : compare_frames
        display_beat_t got;
        int            waited;
        logic          lost;
        compare_done = 1'b0;
        lost         = 1'b0;
        for (int f = 0; f < NUM_BURSTS && !lost; f++) begin
            for (int i = 0; i < FRAME_MAX && !lost; i++) begin
                waited = 0;
                while (beat_q.size() == 0 && waited < WAIT_LIMIT) begin
                    @(negedge clk);
                    waited++;
                end
                if (beat_q.size() == 0 || expected_q.size() == 0) begin
                    $display("Beat %0d of frame %0d is missing or came before its burst", i, f);
                    other_errors++;
                    lost = 1'b1;
                end else begin
                    got = beat_q.pop_front();
                    check_pixel(got.value, expected_q.pop_front(), f, i);
                    check_index(got.index, addr_t'(i), f);
                    check_flag(got.last, i == FRAME_MAX - 1,
                               $sformatf("last flag at frame %0d index %0d", f, i));
                end
            end
        end
        compare_done = 1'b1;
    end

    initial begin : main_sequence
        logic   prev_sign;
        pixel_t frame [FRAME_MAX];
        int     waited;
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample_in    = '0;
        hold_credits = 1'b0;
        stop_run     = 1'b0;
        stim_rng     = 32'd69;
        prev_sign    = 1'b0;                            // Capture clears its sign history on reset
        repeat (10) @(negedge clk);
        reset = 1'b0;
        if ((1 << dut_i.WAVE_DEPTH_LOG2) != FRAME_MAX) begin
            $display("DUT frame length does not match the width of addr_t");
            other_errors++;
            stop_run = 1'b1;
        end
        for (int b = 0; b < NUM_BURSTS && !stop_run; b++) begin
            if (b == NUM_BURSTS - 1) begin
                // Start the stall test from a full credit counter
                wait_for_beats(b * FRAME_MAX, 1'b1, "earlier frames to drain");
                hold_credits = 1'b1;
            end
            build_burst();
            expected_frame(burst, prev_sign, frame);
            foreach (frame[i])
                expected_q.push_back(frame[i]);
            prev_sign = burst[burst.size() - 1][15];
            foreach (burst[i])
                send_sample(burst[i]);
            @(negedge clk);
            sample_valid = 1'b0;
            wait_for_beats(b * FRAME_MAX + (hold_credits ? dut_i.DISPLAY_CREDITS : 1), 1'b0,
                           "the first beats of a frame");
            if (hold_credits && !stop_run) begin
                repeat (40) @(negedge clk);             // No credit comes back in this window
                if (beats_total != b * FRAME_MAX + dut_i.DISPLAY_CREDITS) begin
                    $display("Beats kept flowing after every credit was used up");
                    other_errors++;
                end
                hold_credits = 1'b0;
            end
            repeat (4) @(negedge clk);
        end
        waited = 0;
        while (!compare_done && !stop_run && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!compare_done) begin
            $display("Timeout before all frames were compared");
            other_errors++;
        end
        repeat (20) @(negedge clk);
        if (beats_total != NUM_BURSTS * FRAME_MAX) begin
            $display("Saw %0d beats in total instead of %0d", beats_total, NUM_BURSTS * FRAME_MAX);
            other_errors++;
        end
        report_and_finish();
    end

endmodule

/* list.f */
source/scope_pkg.sv
source/wave_capture.sv
source/wave_ram.sv
source/wave_reader.sv
source/scope_capture_top.sv
testbench/scope_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = scope_tb
FILE_LIST = list.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^Done: no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
